// File: list.f
mc_link_pkg.sv
mc_mem_pkg.sv
mc_reset_ctr.sv
mc_print_stat_snoop.sv
mc_rr_arbiter.sv
mc_cache_to_dram.sv
mc_infra_top.sv
tb_mc_checker.sv
tb_mc_infra.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_mc_infra
FILELIST  = list.f
BUILD_DIR = obj_dir
PASS_MSG  = === PASS ===

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: mc_golden.txt
# host  <idle cycles> <op 0=load 1=store> <addr> <data> <pulse expected> <tag expected>
# dma   <cache> <write> <cache addr> <data>
# expect <write> <channel addr> <write data or read data>, one line per transfer in order
host 2 1 0001d0c 0000abcd 1 0000abcd
host 0 1 0001d0c 12345678 1 12345678
host 3 0 0001d0c deadbeef 0 00000000
host 1 1 0001d10 cafef00d 0 00000000
host 4 1 0001d0c 00000042 1 00000042
dma 0 1 000100 11110000
dma 1 1 000100 22221111
dma 2 1 000200 33332222
dma 3 1 000100 44443333
dma 0 0 000100 00000000
dma 1 0 000100 00000000
dma 2 0 000200 00000000
dma 3 0 000100 00000000
dma 0 1 000104 55554444
dma 1 1 000100 66665555
dma 2 0 000200 00000000
dma 3 0 000100 00000000
expect 1 0000100 11110000
expect 1 1000100 22221111
expect 1 2000200 33332222
expect 1 3000100 44443333
expect 0 0000100 11110000
expect 0 1000100 22221111
expect 0 2000200 33332222
expect 0 3000100 44443333
expect 1 0000104 55554444
expect 1 1000100 66665555
expect 0 2000200 33332222
expect 0 3000100 44443333

// File: tb_mc_infra.sv
`timescale 1ns/1ps

module tb_mc_infra;

  localparam int cycles_per_record = 20;
  localparam int timeout_margin = 200;

  logic                     core_clk;
  logic                     rst_n_i;
  logic                     host_req_v_i;
  mc_link_pkg::link_op_e    host_req_op_i;
  mc_link_pkg::link_addr_t  host_req_addr_i;
  mc_link_pkg::link_data_t  host_req_data_i;
  logic                     print_stat_v_o;
  mc_link_pkg::link_data_t  print_stat_tag_o;
  mc_link_pkg::global_ctr_t print_stat_ctr_o;
  mc_link_pkg::global_ctr_t global_ctr_o;
  mc_mem_pkg::cache_vec_t   dma_req_v_i;
  mc_mem_pkg::cache_vec_t   dma_req_write_i;
  mc_mem_pkg::cache_addr_t [mc_mem_pkg::num_cache-1:0] dma_req_addr_i;
  mc_mem_pkg::dram_data_t  [mc_mem_pkg::num_cache-1:0] dma_req_data_i;
  mc_mem_pkg::cache_vec_t   dma_req_yumi_o;
  mc_mem_pkg::cache_vec_t   dma_rdata_v_o;
  mc_mem_pkg::dram_data_t   dma_rdata_o;
  logic                     dram_req_v_o;
  logic                     dram_write_not_read_o;
  mc_mem_pkg::chan_addr_t   dram_ch_addr_o;
  mc_mem_pkg::dram_data_t   dram_wdata_o;
  logic                     dram_req_yumi_i;
  logic                     dram_rdata_v_i;
  mc_mem_pkg::dram_data_t   dram_rdata_i;
  mc_mem_pkg::chan_addr_t   dram_rdata_ch_addr_i;

  logic [31:0] lfsr_state = 32'hc600_e6b8;
  int cycle_count = 0;
  int cycle_limit = 0;
  // host records {op, addr, data} with idle cycles before each
  int          host_wait_q[$];
  logic [61:0] host_q[$];
  // per cache dma records {write, addr, data}
  logic [56:0] dma_q[mc_mem_pkg::num_cache][$];
  // dram model storage and two stage read pipe {valid, addr, data}
  logic [31:0] mem[logic [25:0]];
  logic [58:0] rd_pipe[2];

  mc_infra_top UUT (.*);

  tb_mc_checker chk (
    .core_clk(core_clk), .rst_n_i(rst_n_i), .host_req_v_i(host_req_v_i),
    .print_stat_v_i(print_stat_v_o), .print_stat_tag_i(print_stat_tag_o),
    .print_stat_ctr_i(print_stat_ctr_o), .global_ctr_i(global_ctr_o),
    .dma_req_yumi_i(dma_req_yumi_o), .dma_rdata_v_i(dma_rdata_v_o), .dma_rdata_i(dma_rdata_o),
    .dram_req_v_i(dram_req_v_o), .dram_write_not_read_i(dram_write_not_read_o),
    .dram_ch_addr_i(dram_ch_addr_o), .dram_wdata_i(dram_wdata_o),
    .dram_req_yumi_i(dram_req_yumi_i)
  );

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic print_summary();
    $display("summary: %0d errors, %0d transfers, %0d markers, %0d cycles",
             chk.error_count, chk.xfer_count, chk.marker_count, cycle_count);
  endtask

  initial begin
    core_clk = 1'b0;
    forever #20 core_clk = ~core_clk;
  end

  always @(posedge core_clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      print_summary();
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ----------------------------------------------------------------------------
  // dram model, random yumi, reads answered two cycles after acceptance
  // ----------------------------------------------------------------------------
  always @(posedge core_clk) begin : dram_model
    logic        ready;
    logic [58:0] fresh;
    ready = rst_n_i;
    fresh = '0;
    if (dram_req_v_o && dram_req_yumi_i) begin
      if (dram_write_not_read_o) begin
        mem[dram_ch_addr_o] = dram_wdata_o;
      end else begin
        fresh = {1'b1, dram_ch_addr_o, mem.exists(dram_ch_addr_o) ? mem[dram_ch_addr_o] : 32'h0};
      end
    end
    #2;
    rd_pipe[1] = rd_pipe[0];
    rd_pipe[0] = fresh;
    {dram_rdata_v_i, dram_rdata_ch_addr_i, dram_rdata_i} = rd_pipe[1];
    // one lfsr bit per cycle gates yumi
    dram_req_yumi_i = ready & lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  end

  task automatic run_host();
    logic [61:0] h;
    int          n;
    while (host_q.size() != 0) begin
      h = host_q.pop_front();
      n = host_wait_q.pop_front();
      host_req_v_i = 1'b0;
      repeat (n) begin
        @(posedge core_clk);
        #2;
      end
      host_req_v_i    = 1'b1;
      host_req_op_i   = mc_link_pkg::link_op_e'(h[61:60]);
      host_req_addr_i = h[59:32];
      host_req_data_i = h[31:0];
      @(posedge core_clk);
      #2;
    end
    host_req_v_i = 1'b0;
  endtask

  // each cache holds its request until its yumi bit is seen at an edge
  task automatic run_dma();
    mc_mem_pkg::cache_vec_t y;
    logic [56:0]            r;
    y = '0;
    forever begin
      for (int c = 0; c < mc_mem_pkg::num_cache; c++) begin
        if (y[c]) dma_req_v_i[c] = 1'b0;
        if (!dma_req_v_i[c] && dma_q[c].size() != 0) begin
          r = dma_q[c].pop_front();
          dma_req_v_i[c]     = 1'b1;
          dma_req_write_i[c] = r[56];
          dma_req_addr_i[c]  = r[55:32];
          dma_req_data_i[c]  = r[31:0];
        end
      end
      if (dma_req_v_i == '0) break;
      @(posedge core_clk);
      y = dma_req_yumi_o;
      #2;
    end
  endtask

  initial begin : main
    int          fd;
    int          records;
    int          wait_n;
    int          op;
    int          cid;
    int          wr;
    int          pulse;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] t;
    string       line;
    string       kind;
    rst_n_i = 1'b0;
    host_req_v_i = 1'b0;
    host_req_op_i = mc_link_pkg::op_load;
    host_req_addr_i = '0;
    host_req_data_i = '0;
    dma_req_v_i = '0;
    dma_req_write_i = '0;
    dma_req_addr_i = '0;
    dma_req_data_i = '0;
    dram_req_yumi_i = 1'b0;
    dram_rdata_v_i = 1'b0;
    dram_rdata_i = '0;
    dram_rdata_ch_addr_i = '0;
    rd_pipe[0] = '0;
    rd_pipe[1] = '0;
    records = 0;
    fd = $fopen("mc_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open mc_golden.txt");
      $display("=== FAIL ===");
      $finish;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") continue;
        void'($sscanf(line, "%s", kind));
        records++;
        if (kind == "host") begin
          void'($sscanf(line, "%s %d %d %h %h %d %h", kind, wait_n, op, a, d, pulse, t));
          host_wait_q.push_back(wait_n);
          host_q.push_back({op[1:0], a[27:0], d});
          chk.add_marker({pulse[0], t});
        end else if (kind == "dma") begin
          void'($sscanf(line, "%s %d %d %h %h", kind, cid, wr, a, d));
          dma_q[cid].push_back({wr[0], a[23:0], d});
        end else if (kind == "expect") begin
          void'($sscanf(line, "%s %d %h %h", kind, wr, a, d));
          chk.add_xfer({wr[0], a[25:0], d});
        end
      end
      $fclose(fd);
      cycle_limit = records * cycles_per_record + timeout_margin;
      repeat (8) @(posedge core_clk);
      #2;
      rst_n_i = 1'b1;
      // let the delayed reset clear before traffic starts
      repeat (4) @(posedge core_clk);
      #2;
      fork
        run_host();
        run_dma();
      join
      while (chk.pending() != 0) @(posedge core_clk);
      repeat (4) @(posedge core_clk);
      print_summary();
      if (chk.error_count == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

endmodule

// File: tb_mc_checker.sv
`timescale 1ns/1ps

module tb_mc_checker (
  input logic                     core_clk,
  input logic                     rst_n_i,
  input logic                     host_req_v_i,
  input logic                     print_stat_v_i,
  input mc_link_pkg::link_data_t  print_stat_tag_i,
  input mc_link_pkg::global_ctr_t print_stat_ctr_i,
  input mc_link_pkg::global_ctr_t global_ctr_i,
  input mc_mem_pkg::cache_vec_t   dma_req_yumi_i,
  input mc_mem_pkg::cache_vec_t   dma_rdata_v_i,
  input mc_mem_pkg::dram_data_t   dma_rdata_i,
  input logic                     dram_req_v_i,
  input logic                     dram_write_not_read_i,
  input mc_mem_pkg::chan_addr_t   dram_ch_addr_i,
  input mc_mem_pkg::dram_data_t   dram_wdata_i,
  input logic                     dram_req_yumi_i
);

  int error_count = 0;
  int xfer_count = 0;
  int marker_count = 0;
  // rising edges that have sampled rst_n_i high
  int edges_high = 0;

  // expected transfers {write, chan addr, data}, reads {chan addr, data}, markers {pulse, tag}
  logic [58:0] xfer_q[$];
  logic [57:0] read_q[$];
  logic [32:0] mark_q[$];

  logic                     host_v_last = 1'b0;
  logic                     stall_last = 1'b0;
  // model count in the request cycle
  mc_link_pkg::global_ctr_t ctr_last;
  mc_mem_pkg::chan_addr_t   addr_held;
  logic                     write_held;
  mc_mem_pkg::dram_data_t   wdata_held;

  function void add_xfer(input logic [58:0] x);
    xfer_q.push_back(x);
  endfunction

  function void add_marker(input logic [32:0] m);
    mark_q.push_back(m);
  endfunction

  function int pending();
    return xfer_q.size() + read_q.size() + mark_q.size();
  endfunction

  task automatic report_value(input string test, input logic [63:0] exp, input logic [63:0] act);
    $display("** Error %s: expected %h, actual %h", test, exp, act);
    error_count++;
  endtask

  task automatic report_fault(input string msg);
    $display("error: %s", msg);
    error_count++;
  endtask

  // ----------------------------------------------------------------------------
  // everything is sampled at the falling edge, half a cycle from any change
  // ----------------------------------------------------------------------------
  always @(negedge core_clk) begin : watch
    logic [58:0]              x;
    logic [57:0]              r;
    logic [32:0]              m;
    mc_link_pkg::global_ctr_t exp_ctr;
    // counter sits at zero for reset_depth edges after the release
    exp_ctr = (edges_high > mc_link_pkg::reset_depth)
            ? mc_link_pkg::global_ctr_t'(edges_high - mc_link_pkg::reset_depth) : '0;
    if (edges_high > 0) begin
      if (global_ctr_i !== exp_ctr) report_value("global_ctr", exp_ctr, global_ctr_i);
      // marker answers the request seen one cycle back
      if (host_v_last) begin
        if (mark_q.size() == 0) begin
          report_fault("host request with no golden marker record");
        end else begin
          m = mark_q.pop_front();
          if (print_stat_v_i !== m[32]) begin
            report_value("print_stat_v", m[32], print_stat_v_i);
          end else if (m[32]) begin
            marker_count++;
            if (print_stat_tag_i !== m[31:0]) report_value("print_stat_tag", m[31:0], print_stat_tag_i);
            if (print_stat_ctr_i !== ctr_last) report_value("print_stat_ctr", ctr_last, print_stat_ctr_i);
          end
        end
      end else if (print_stat_v_i !== 1'b0) begin
        report_fault("print-stat pulse without a host request the cycle before");
      end
      // a stalled request must hold every field
      if (stall_last && (dram_req_v_i !== 1'b1 || dram_ch_addr_i !== addr_held
          || dram_write_not_read_i !== write_held || dram_wdata_i !== wdata_held)) begin
        report_fault("dram request changed while yumi was low");
      end
      if (dram_req_v_i && dram_req_yumi_i) begin
        xfer_count++;
        if (xfer_q.size() == 0) begin
          report_fault("dram transfer with no golden expect record");
        end else begin
          x = xfer_q.pop_front();
          // top two channel address bits name the cache
          if (dram_ch_addr_i !== x[57:32]) report_value("chan_addr", x[57:32], dram_ch_addr_i);
          if (dram_write_not_read_i !== x[58]) report_value("write_flag", x[58], dram_write_not_read_i);
          if (x[58] && dram_wdata_i !== x[31:0]) report_value("wdata", x[31:0], dram_wdata_i);
          if (dma_req_yumi_i !== (mc_mem_pkg::cache_vec_t'(1) << x[57:56])) begin
            report_value("rr_yumi", mc_mem_pkg::cache_vec_t'(1) << x[57:56], dma_req_yumi_i);
          end
          if (!x[58]) read_q.push_back(x[57:0]);
        end
      end else if (dma_req_yumi_i !== '0) begin
        report_fault("cache yumi seen outside a dram transfer");
      end
      // read response goes to the cache in the returned address only
      if (dma_rdata_v_i !== '0) begin
        if (read_q.size() == 0) begin
          report_fault("read response with no outstanding read");
        end else begin
          r = read_q.pop_front();
          if (dma_rdata_v_i !== (mc_mem_pkg::cache_vec_t'(1) << r[57:56])) begin
            report_value("read_steer", mc_mem_pkg::cache_vec_t'(1) << r[57:56], dma_rdata_v_i);
          end
          if (dma_rdata_i !== r[31:0]) report_value("read_data", r[31:0], dma_rdata_i);
        end
      end
    end
    host_v_last = host_req_v_i;
    ctr_last    = exp_ctr;
    stall_last  = dram_req_v_i && !dram_req_yumi_i;
    addr_held   = dram_ch_addr_i;
    write_held  = dram_write_not_read_i;
    wdata_held  = dram_wdata_i;
    if (rst_n_i) edges_high++;
  end

endmodule

// File: mc_infra_top.sv
`timescale 1ns/1ps

module mc_infra_top (
  input  logic                                                 core_clk,
  input  logic                                                 rst_n_i,
  // host link requests, observed only
  input  logic                                                 host_req_v_i,
  input  mc_link_pkg::link_op_e                                host_req_op_i,
  input  mc_link_pkg::link_addr_t                              host_req_addr_i,
  input  mc_link_pkg::link_data_t                              host_req_data_i,
  // print-stat marker
  output logic                                                 print_stat_v_o,
  output mc_link_pkg::link_data_t                              print_stat_tag_o,
  output mc_link_pkg::global_ctr_t                             print_stat_ctr_o,
  output mc_link_pkg::global_ctr_t                             global_ctr_o,
  // cache dma ports
  input  mc_mem_pkg::cache_vec_t                               dma_req_v_i,
  input  mc_mem_pkg::cache_vec_t                               dma_req_write_i,
  input  mc_mem_pkg::cache_addr_t [mc_mem_pkg::num_cache-1:0]  dma_req_addr_i,
  input  mc_mem_pkg::dram_data_t  [mc_mem_pkg::num_cache-1:0]  dma_req_data_i,
  output mc_mem_pkg::cache_vec_t                               dma_req_yumi_o,
  output mc_mem_pkg::cache_vec_t                               dma_rdata_v_o,
  output mc_mem_pkg::dram_data_t                               dma_rdata_o,
  // dram channel
  output logic                                                 dram_req_v_o,
  output logic                                                 dram_write_not_read_o,
  output mc_mem_pkg::chan_addr_t                               dram_ch_addr_o,
  output mc_mem_pkg::dram_data_t                               dram_wdata_o,
  input  logic                                                 dram_req_yumi_i,
  input  logic                                                 dram_rdata_v_i,
  input  mc_mem_pkg::dram_data_t                               dram_rdata_i,
  input  mc_mem_pkg::chan_addr_t                               dram_rdata_ch_addr_i
);

  // delayed reset, active high, shared by snoop and channel adapter
  logic reset_dly;

  // --------------------------------------------------------------------------
  // reset pipeline and cycle counter
  // --------------------------------------------------------------------------
  mc_reset_ctr reset_ctr (
    .core_clk     (core_clk),
    .rst_n_i      (rst_n_i),
    .reset_dly_o  (reset_dly),
    .global_ctr_o (global_ctr_o)
  );

  // --------------------------------------------------------------------------
  // print-stat snoop on the host link
  // --------------------------------------------------------------------------
  mc_print_stat_snoop print_stat_snoop (
    .core_clk         (core_clk),
    .reset_i          (reset_dly),
    .host_req_v_i     (host_req_v_i),
    .host_req_op_i    (host_req_op_i),
    .host_req_addr_i  (host_req_addr_i),
    .host_req_data_i  (host_req_data_i),
    .global_ctr_i     (global_ctr_o),
    .print_stat_v_o   (print_stat_v_o),
    .print_stat_tag_o (print_stat_tag_o),
    .print_stat_ctr_o (print_stat_ctr_o)
  );

  // --------------------------------------------------------------------------
  // caches onto one dram channel
  // --------------------------------------------------------------------------
  mc_cache_to_dram cache_to_dram (
    .core_clk              (core_clk),
    .reset_i               (reset_dly),
    .dma_req_v_i           (dma_req_v_i),
    .dma_req_write_i       (dma_req_write_i),
    .dma_req_addr_i        (dma_req_addr_i),
    .dma_req_data_i        (dma_req_data_i),
    .dma_req_yumi_o        (dma_req_yumi_o),
    .dram_req_v_o          (dram_req_v_o),
    .dram_write_not_read_o (dram_write_not_read_o),
    .dram_ch_addr_o        (dram_ch_addr_o),
    .dram_wdata_o          (dram_wdata_o),
    .dram_req_yumi_i       (dram_req_yumi_i),
    .dram_rdata_v_i        (dram_rdata_v_i),
    .dram_rdata_i          (dram_rdata_i),
    .dram_rdata_ch_addr_i  (dram_rdata_ch_addr_i),
    .dma_rdata_v_o         (dma_rdata_v_o),
    .dma_rdata_o           (dma_rdata_o)
  );

endmodule

// File: mc_cache_to_dram.sv
`timescale 1ns/1ps

module mc_cache_to_dram (
  input  logic                                                 core_clk,
  input  logic                                                 reset_i,
  // cache dma request side
  input  mc_mem_pkg::cache_vec_t                               dma_req_v_i,
  input  mc_mem_pkg::cache_vec_t                               dma_req_write_i,
  input  mc_mem_pkg::cache_addr_t [mc_mem_pkg::num_cache-1:0]  dma_req_addr_i,
  input  mc_mem_pkg::dram_data_t  [mc_mem_pkg::num_cache-1:0]  dma_req_data_i,
  output mc_mem_pkg::cache_vec_t                               dma_req_yumi_o,
  // dram channel request side
  output logic                                                 dram_req_v_o,
  output logic                                                 dram_write_not_read_o,
  output mc_mem_pkg::chan_addr_t                               dram_ch_addr_o,
  output mc_mem_pkg::dram_data_t                               dram_wdata_o,
  input  logic                                                 dram_req_yumi_i,
  // dram read response side
  input  logic                                                 dram_rdata_v_i,
  input  mc_mem_pkg::dram_data_t                               dram_rdata_i,
  input  mc_mem_pkg::chan_addr_t                               dram_rdata_ch_addr_i,
  output mc_mem_pkg::cache_vec_t                               dma_rdata_v_o,
  output mc_mem_pkg::dram_data_t                               dma_rdata_o
);

  mc_mem_pkg::cache_vec_t grant;
  mc_mem_pkg::cache_id_t  grant_id;
  logic                   accept;
  mc_mem_pkg::cache_id_t  rsp_id;

  // --------------------------------------------------------------------------
  // request arbitration
  // --------------------------------------------------------------------------

  // channel sees a request as soon as any cache asks
  assign dram_req_v_o = |dma_req_v_i;
  assign accept       = dram_req_v_o && dram_req_yumi_i;

  mc_rr_arbiter arb (
    .core_clk   (core_clk),
    .reset_i    (reset_i),
    .req_i      (dma_req_v_i),
    .accept_i   (accept),
    .grant_o    (grant),
    .grant_id_o (grant_id)
  );

  // --------------------------------------------------------------------------
  // request mux and channel address
  // --------------------------------------------------------------------------

  // fields of the granted cache go straight through
  assign dram_write_not_read_o = dma_req_write_i[grant_id];
  assign dram_wdata_o          = dma_req_data_i[grant_id];

  // cache index sits in the msbs so each cache owns its own slice of dram
  assign dram_ch_addr_o = {grant_id, dma_req_addr_i[grant_id]};

  // yumi goes back in the same cycle, to the granted cache only
  assign dma_req_yumi_o = grant & {mc_mem_pkg::num_cache{dram_req_yumi_i}};

  // --------------------------------------------------------------------------
  // read response steering
  // --------------------------------------------------------------------------

  // index bits of the returned address name the owner
  assign rsp_id = dram_rdata_ch_addr_i[mc_mem_pkg::chan_addr_width-1 -: mc_mem_pkg::cache_id_width];

  always_comb begin
    dma_rdata_v_o = '0;
    if (dram_rdata_v_i) begin
      dma_rdata_v_o = mc_mem_pkg::cache_vec_t'(1) << rsp_id;
    end
  end

  // data is shared, valid picks the receiver
  assign dma_rdata_o = dram_rdata_i;

  // a stalled request must look the same on the next cycle
  // relies on the caches holding their fields and on the arbiter lock
  chan_hold_a: assert property (@(posedge core_clk) disable iff (reset_i)
    (dram_req_v_o && !dram_req_yumi_i) |=> (dram_req_v_o
      && $stable(dram_ch_addr_o)
      && $stable(dram_write_not_read_o)
      && $stable(dram_wdata_o))
  ) else $error("dram request changed while stalled");

endmodule

// File: mc_rr_arbiter.sv
`timescale 1ns/1ps

module mc_rr_arbiter (
  input  logic                   core_clk,
  input  logic                   reset_i,
  input  mc_mem_pkg::cache_vec_t req_i,
  input  logic                   accept_i,
  output mc_mem_pkg::cache_vec_t grant_o,
  output mc_mem_pkg::cache_id_t  grant_id_o
);

  // rotating priority pointer, first cache to look at
  mc_mem_pkg::cache_id_t ptr_r;
  // grant is frozen while the channel holds off
  logic                  locked_r;
  mc_mem_pkg::cache_id_t lock_id_r;

  logic                  scan_v;
  mc_mem_pkg::cache_id_t scan_id;

  // --------------------------------------------------------------------------
  // priority search from the pointer, wrapping around
  // --------------------------------------------------------------------------
  always_comb begin
    int idx;
    scan_v  = 1'b0;
    scan_id = '0;
    for (int k = 0; k < mc_mem_pkg::num_cache; k++) begin
      idx = (int'(ptr_r) + k) % mc_mem_pkg::num_cache;
      if (!scan_v && req_i[idx]) begin
        scan_v  = 1'b1;
        scan_id = mc_mem_pkg::cache_id_t'(idx);
      end
    end
  end

  // a stalled grant wins over a fresh search
  // so a late request cannot steal the channel
  assign grant_id_o = locked_r ? lock_id_r : scan_id;
  assign grant_o    = (locked_r || scan_v) ? (mc_mem_pkg::cache_vec_t'(1) << grant_id_o) : '0;

  // --------------------------------------------------------------------------
  // pointer and lock update
  // --------------------------------------------------------------------------
  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      ptr_r    <= '0;
      locked_r <= 1'b0;
    end else begin
      locked_r <= (|grant_o) && !accept_i;
      // next search starts just past the cache that was served
      if (accept_i) begin
        ptr_r <= mc_mem_pkg::cache_id_t'((int'(grant_id_o) + 1) % mc_mem_pkg::num_cache);
      end
    end
  end

  always_ff @(posedge core_clk) begin
    lock_id_r <= grant_id_o;
  end

  // any pending request gets exactly one grant
  grant_onehot_a: assert property (@(posedge core_clk) disable iff (reset_i)
    (|req_i) |-> $onehot(grant_o)
  ) else $error("arbiter grant is not one-hot while caches request");

  // a held grant relies on the cache keeping its request up
  grant_req_a: assert property (@(posedge core_clk) disable iff (reset_i)
    (grant_o & ~req_i) == '0
  ) else $error("grant without a matching request");

endmodule

// File: mc_print_stat_snoop.sv
`timescale 1ns/1ps

module mc_print_stat_snoop (
  input  logic                     core_clk,
  input  logic                     reset_i,
  input  logic                     host_req_v_i,
  input  mc_link_pkg::link_op_e    host_req_op_i,
  input  mc_link_pkg::link_addr_t  host_req_addr_i,
  input  mc_link_pkg::link_data_t  host_req_data_i,
  input  mc_link_pkg::global_ctr_t global_ctr_i,
  output logic                     print_stat_v_o,
  output mc_link_pkg::link_data_t  print_stat_tag_o,
  output mc_link_pkg::global_ctr_t print_stat_ctr_o
);

  // --------------------------------------------------------------------------
  // request qualification
  // --------------------------------------------------------------------------

  logic hit;

  // only stores to the print-stat word count, loads there are ignored
  assign hit = host_req_v_i
            && (host_req_op_i == mc_link_pkg::op_store)
            && (host_req_addr_i == mc_link_pkg::print_stat_addr);

  // --------------------------------------------------------------------------
  // marker registers
  // --------------------------------------------------------------------------

  logic                     stat_v_r;
  mc_link_pkg::link_data_t  stat_tag_r;
  mc_link_pkg::global_ctr_t stat_ctr_r;

  // pulse lands one cycle after the qualifying request
  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      stat_v_r <= 1'b0;
    end else begin
      stat_v_r <= hit;
    end
  end

  // tag is the store data
  // counter snapshot is taken in the request cycle, held until the next hit
  always_ff @(posedge core_clk) begin
    if (hit) begin
      stat_tag_r <= host_req_data_i;
      stat_ctr_r <= global_ctr_i;
    end
  end

  assign print_stat_v_o   = stat_v_r;
  assign print_stat_tag_o = stat_tag_r;
  assign print_stat_ctr_o = stat_ctr_r;

  // back to back markers need a store to the print-stat word on the port
  // in each of the two cycles before
  stat_pulse_a: assert property (@(posedge core_clk) disable iff (reset_i)
    (print_stat_v_o && $past(print_stat_v_o))
      |-> ($past(host_req_v_i) && $past(host_req_v_i, 2)
        && ($past(host_req_op_i) == mc_link_pkg::op_store)
        && ($past(host_req_op_i, 2) == mc_link_pkg::op_store)
        && ($past(host_req_addr_i) == mc_link_pkg::print_stat_addr)
        && ($past(host_req_addr_i, 2) == mc_link_pkg::print_stat_addr))
  ) else $error("print-stat marker held without back to back stores");

endmodule

// File: mc_reset_ctr.sv
`timescale 1ns/1ps

module mc_reset_ctr (
  input  logic                     core_clk,
  input  logic                     rst_n_i,
  output logic                     reset_dly_o,
  output mc_link_pkg::global_ctr_t global_ctr_o
);

  // --------------------------------------------------------------------------
  // reset delay chain
  // --------------------------------------------------------------------------

  // stage 0 takes the inverted pin, the last stage is the delayed reset
  logic [mc_link_pkg::reset_depth-1:0] reset_pipe_r;

  always_ff @(posedge core_clk) begin
    reset_pipe_r[0] <= ~rst_n_i;
    for (int i = 1; i < mc_link_pkg::reset_depth; i++) begin
      reset_pipe_r[i] <= reset_pipe_r[i-1];
    end
  end

  assign reset_dly_o = reset_pipe_r[mc_link_pkg::reset_depth-1];

  // --------------------------------------------------------------------------
  // global cycle counter
  // --------------------------------------------------------------------------

  mc_link_pkg::global_ctr_t ctr_r;

  // held at zero by the delayed reset, one step per edge afterwards
  always_ff @(posedge core_clk) begin
    if (reset_dly_o) begin
      ctr_r <= '0;
    end else begin
      ctr_r <= ctr_r + 1'b1;
    end
  end

  assign global_ctr_o = ctr_r;

  // pin high reset_depth+1 edges back means the delayed reset had cleared
  // in time for the last update, so the count moves by exactly one
  ctr_step_a: assert property (@(posedge core_clk)
    $past(rst_n_i, mc_link_pkg::reset_depth + 1)
      |-> (global_ctr_o == $past(global_ctr_o) + 1'b1)
  ) else $error("global counter did not advance by one");

endmodule

// File: mc_mem_pkg.sv
package mc_mem_pkg;

  // --------------------------------------------------------------------------
  // caches sharing one dram channel
  // --------------------------------------------------------------------------

  localparam int num_cache = 4;
  localparam int cache_id_width = $clog2(num_cache);

  // byte address as issued by one cache dma port
  localparam int cache_addr_width = 24;

  // channel address puts the cache index above the cache address
  localparam int chan_addr_width = cache_id_width + cache_addr_width;

  // one dma data word
  localparam int dram_data_width = 32;

  typedef logic [cache_id_width-1:0]   cache_id_t;
  typedef logic [cache_addr_width-1:0] cache_addr_t;
  typedef logic [chan_addr_width-1:0]  chan_addr_t;
  typedef logic [dram_data_width-1:0]  dram_data_t;

  // one bit per cache, used for valid, yumi and grant vectors
  typedef logic [num_cache-1:0] cache_vec_t;

endpackage

// File: mc_link_pkg.sv
package mc_link_pkg;

  // --------------------------------------------------------------------------
  // host link
  // --------------------------------------------------------------------------

  // word address and data width of the host request stream
  localparam int link_addr_width = 28;
  localparam int link_data_width = 32;

  typedef logic [link_addr_width-1:0] link_addr_t;
  typedef logic [link_data_width-1:0] link_data_t;

  // request opcodes seen on the host link
  typedef enum logic [1:0] {
    op_load  = 2'b00,
    op_store = 2'b01
  } link_op_e;

  // a store to this word marks a print-stat event
  localparam link_addr_t print_stat_addr = 28'h0001d0c;

  // --------------------------------------------------------------------------
  // reset and global counter
  // --------------------------------------------------------------------------

  // flops that reset passes through before the counter sees it
  // matches the reset pipeline inside the tile array
  localparam int reset_depth = 2;

  // free running cycle count for profiling and print-stat stamps
  localparam int global_ctr_width = 64;

  typedef logic [global_ctr_width-1:0] global_ctr_t;

endpackage
